//--- src.f
design/dump_pkg.sv
design/text_bus_if.sv
design/dump_sram.sv
design/text_buffer.sv
design/hex_dump_ctrl.sv
design/mem_dump_top.sv
test/tb_mem_dump.sv

//--- test/tb_mem_dump.sv
`timescale 1ns/1ps

module tb_mem_dump;
  import dump_pkg::*;

  localparam int FRAME_TIMEOUT = 20000;
  localparam int FRAME_CELLS   = 1360;
  localparam int PAGE_WORDS    = 256;

  logic                  clk;
  logic                  rst;
  logic [PAGE_W-1:0]     page_i;
  logic                  wr_en_i;
  logic [WORD_ADR_W-1:0] wr_adr_i;
  logic [WORD_W-1:0]     wr_dat_i;
  logic [TEXT_ADR_W-1:0] scan_adr_i;
  logic [WORD_W-1:0]     scan_dat_o;
  logic                  frame_done_o;

  logic [WORD_W-1:0] shadow [2**WORD_ADR_W];
  logic [31:0]       rnd_state;
  int                cmp_errs;
  int                pulse_errs;
  int                timeouts;
  int                frames_seen;
  int                frame_len;

  mem_dump_top mem_dump_top_inst (
    .clk          (clk),
    .rst          (rst),
    .page_i       (page_i),
    .wr_en_i      (wr_en_i),
    .wr_adr_i     (wr_adr_i),
    .wr_dat_i     (wr_dat_i),
    .scan_adr_i   (scan_adr_i),
    .scan_dat_o   (scan_dat_o),
    .frame_done_o (frame_done_o)
  );

  always #2 clk = ~clk;

  // Cycles since reset or since the previous frame done pulse
  always @(posedge clk) begin
    if (rst || frame_done_o) begin
      frame_len <= 0;
    end else begin
      frame_len <= frame_len + 1;
    end
  end

  // Frame done is a single-cycle pulse
  frame_done_pulse: assert property (@(posedge clk) disable iff (rst)
    frame_done_o |=> !frame_done_o)
  else begin
    $display("Error frame_done_o pulse: expected 0 one cycle after the pulse, actual 1");
    pulse_errs++;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] digit_ascii(input int n);
    string digits;
    digits = "0123456789abcdef";
    return digits[n];
  endfunction

  // Expected cell content for one screen address on the given page
  function automatic logic [15:0] expected_cell(input int adr, input int page);
    int          k;
    int          row;
    int          col;
    int          word_idx;
    int          pos;
    logic [15:0] w;
    if (adr < int'(DATA_BASE)) begin
      k = adr - int'(HDR_BASE);
      if (k % 5 == 3) begin
        return {ATTR_LABEL, digit_ascii((2 * (k / 5)) % 16)};
      end
      return {ATTR_DATA, CHAR_BLANK};
    end
    row = (adr - int'(DATA_BASE)) / SCREEN_COLS;
    col = (adr - int'(DATA_BASE)) % SCREEN_COLS;
    if (col == 0) begin
      return {ATTR_LABEL, digit_ascii(row)};
    end
    word_idx = (col - 1) / 5;
    pos      = (col - 1) % 5;
    // Separator after each word but the last
    if (pos == 4) begin
      return {ATTR_DATA, CHAR_BLANK};
    end
    w = shadow[page * PAGE_WORDS + row * WORDS_PER_ROW + word_idx];
    return {ATTR_DATA, digit_ascii((w >> (12 - 4 * pos)) & 16'hf)};
  endfunction

  task automatic load_page(input int page);
    int                    off;
    logic [WORD_ADR_W-1:0] adr;
    for (off = 0; off < PAGE_WORDS; off++) begin
      adr = WORD_ADR_W'(page * PAGE_WORDS + off);
      rnd_state = xorshift(rnd_state);
      shadow[adr] = rnd_state[15:0];
      @(posedge clk);
      wr_en_i  <= 1'b1;
      wr_adr_i <= adr;
      wr_dat_i <= rnd_state[15:0];
    end
    @(posedge clk);
    wr_en_i <= 1'b0;
  endtask

  task automatic wait_frame_done(input string name);
    int n;
    if (timeouts == 0) begin
      n = 0;
      @(negedge clk);
      while (frame_done_o !== 1'b1 && n < FRAME_TIMEOUT) begin
        assert (frame_done_o === 1'b0) else begin
          $display("Error %s: expected frame_done_o 0, actual %b", name, frame_done_o);
          cmp_errs++;
        end
        @(negedge clk);
        n++;
      end
      if (frame_done_o !== 1'b1) begin
        $display("Timeout: frame_done_o did not rise within %0d cycles in %s",
                 FRAME_TIMEOUT, name);
        timeouts++;
      end else begin
        frames_seen++;
        // Every cell needs at least a req cycle and an ack cycle
        assert (frame_len >= 2 * FRAME_CELLS) else begin
          $display("Error %s: expected at least %0d cycles per frame, actual %0d",
                   name, 2 * FRAME_CELLS, frame_len);
          cmp_errs++;
        end
        @(negedge clk);
        assert (frame_done_o === 1'b0) else begin
          $display("Error %s: expected frame_done_o 0 after pulse, actual %b",
                   name, frame_done_o);
          pulse_errs++;
        end
      end
    end
  endtask

  // Read-back runs ahead of the next frame's writer, two cycles per cell
  task automatic check_screen(input string name, input int page);
    int          a;
    logic [15:0] exp;
    logic [15:0] got;
    if (timeouts == 0) begin
      for (a = HDR_BASE; a < DATA_BASE + DATA_ROWS * SCREEN_COLS; a++) begin
        exp = expected_cell(a, page);
        @(posedge clk);
        scan_adr_i <= TEXT_ADR_W'(a);
        @(posedge clk);
        @(negedge clk);
        got = scan_dat_o;
        assert (got === exp) else begin
          $display("Error %s cell %0d: expected %h, actual %h", name, a, exp, got);
          cmp_errs++;
        end
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    page_i      = PAGE_W'(1);
    wr_en_i     = 1'b0;
    wr_adr_i    = '0;
    wr_dat_i    = '0;
    scan_adr_i  = '0;
    rnd_state   = 32'haab7;
    cmp_errs    = 0;
    pulse_errs  = 0;
    timeouts    = 0;
    frames_seen = 0;

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // First frame shows a half-loaded page and is not compared
    fork
      begin
        load_page(1);
        load_page(2);
      end
      wait_frame_done("first frame");
    join

    wait_frame_done("page 1 frame");
    repeat (50) @(posedge clk);
    page_i <= PAGE_W'(2);
    check_screen("page 1 screen", 1);

    // Frame running during the page change stays on page 1
    wait_frame_done("page change frame");
    check_screen("page 1 kept", 1);

    wait_frame_done("page 2 frame");
    check_screen("page 2 screen", 2);

    $display("errors: compare %0d, pulse %0d, timeout %0d, frames seen %0d",
             cmp_errs, pulse_errs, timeouts, frames_seen);
    if (cmp_errs == 0 && pulse_errs == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- design/mem_dump_top.sv
`timescale 1ns/1ps

module mem_dump_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dump_pkg::PAGE_W-1:0]     page_i,
  input  logic                            wr_en_i,
  input  logic [dump_pkg::WORD_ADR_W-1:0] wr_adr_i,
  input  logic [dump_pkg::WORD_W-1:0]     wr_dat_i,
  input  logic [dump_pkg::TEXT_ADR_W-1:0] scan_adr_i,
  output logic [dump_pkg::WORD_W-1:0]     scan_dat_o,
  output logic                            frame_done_o
);
  import dump_pkg::*;

  logic [WORD_ADR_W-1:0] rd_adr;
  logic [WORD_W-1:0]     rd_dat;

  text_bus_if tb_bus ();

  hex_dump_ctrl hex_dump_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .page_i       (page_i),
    .rd_dat_i     (rd_dat),
    .rd_adr_o     (rd_adr),
    .frame_done_o (frame_done_o),
    .tb           (tb_bus.master)
  );

  dump_sram dump_sram_inst (
    .clk      (clk),
    .wr_en_i  (wr_en_i),
    .wr_adr_i (wr_adr_i),
    .wr_dat_i (wr_dat_i),
    .rd_adr_i (rd_adr),
    .rd_dat_o (rd_dat)
  );

  text_buffer text_buffer_inst (
    .clk        (clk),
    .rst        (rst),
    .scan_adr_i (scan_adr_i),
    .scan_dat_o (scan_dat_o),
    .tb         (tb_bus.slave)
  );

endmodule

//--- design/hex_dump_ctrl.sv
`timescale 1ns/1ps

module hex_dump_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dump_pkg::PAGE_W-1:0]     page_i,
  input  logic [dump_pkg::WORD_W-1:0]     rd_dat_i,
  output logic [dump_pkg::WORD_ADR_W-1:0] rd_adr_o,
  output logic                            frame_done_o,
  text_bus_if.master                      tb
);
  import dump_pkg::*;

  typedef enum logic [2:0] {
    ST_HDR,
    ST_LABEL,
    ST_RD,
    ST_DIG,
    ST_BLANK,
    ST_NEXT_ROW,
    ST_FRAME_END
  } state_t;

  state_t                            state;
  logic [PAGE_W-1:0]                 page_q;
  logic [TEXT_ADR_W-1:0]             cell_adr;
  logic [WORD_ADR_W-PAGE_W-1:0]      word_off;
  logic [1:0]                        nib_idx;
  logic [2:0]                        spacer;
  logic [3:0]                        lbl_cnt;
  logic                              rd_wait;
  logic [WORD_W-1:0]                 word_q;
  logic                              done_q;

  logic                              is_cell;
  logic                              issue;
  logic                              cell_ack;
  logic                              spacer_on;
  logic [3:0]                        cur_nib;
  logic [WORD_W-1:0]                 cell_dat;
  logic                              word_last;
  logic                              row_last;

  assign rd_adr_o     = {page_q, word_off};
  assign frame_done_o = done_q;

  assign is_cell   = (state == ST_HDR) || (state == ST_LABEL) ||
                     (state == ST_DIG) || (state == ST_BLANK);
  // New request only once the previous ack has fallen
  assign issue     = is_cell && !tb.req && !tb.ack;
  assign cell_ack  = is_cell && tb.req && tb.ack;
  assign spacer_on = (spacer != 3'd0);
  assign cur_nib   = word_q[4*(3-nib_idx) +: 4];
  assign word_last = (word_off[3:0] == 4'(WORDS_PER_ROW - 1));
  assign row_last  = (word_off[7:4] == 4'(DATA_ROWS - 1));

  always_comb begin
    case (state)
      ST_HDR: begin
        if (spacer_on) begin
          cell_dat = {ATTR_DATA, CHAR_BLANK};
        end else begin
          cell_dat = {ATTR_LABEL, hex_char(lbl_cnt)};
        end
      end
      ST_LABEL: cell_dat = {ATTR_LABEL, hex_char(word_off[7:4])};
      ST_DIG:   cell_dat = {ATTR_DATA, hex_char(cur_nib)};
      default:  cell_dat = {ATTR_DATA, CHAR_BLANK};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_HDR;
      tb.req   <= 1'b0;
      done_q   <= 1'b0;
      page_q   <= '0;
      cell_adr <= HDR_BASE;
      word_off <= '0;
      nib_idx  <= 2'd0;
      spacer   <= 3'd3;
      lbl_cnt  <= 4'd0;
      rd_wait  <= 1'b0;
    end else begin
      done_q <= 1'b0;

      if (issue) begin
        tb.req <= 1'b1;
      end
      if (cell_ack) begin
        tb.req   <= 1'b0;
        cell_adr <= cell_adr + 1'b1;
      end

      case (state)
        ST_HDR: begin
          // Page is sampled with the first cell of the frame
          if (issue && cell_adr == HDR_BASE) begin
            page_q <= page_i;
          end
          if (cell_ack) begin
            spacer  <= spacer_on ? (spacer - 3'd1) : 3'd4;
            lbl_cnt <= spacer_on ? lbl_cnt : (lbl_cnt + 4'd2);
            if (cell_adr == DATA_BASE - 1'b1) begin
              state <= ST_LABEL;
            end
          end
        end

        ST_LABEL: begin
          if (cell_ack) begin
            state <= ST_RD;
          end
        end

        // Address is already on rd_adr_o, data shows up on the second cycle
        ST_RD: begin
          if (!rd_wait) begin
            rd_wait <= 1'b1;
          end else begin
            rd_wait <= 1'b0;
            state   <= ST_DIG;
          end
        end

        ST_DIG: begin
          if (cell_ack) begin
            nib_idx <= nib_idx + 2'd1;
            if (nib_idx == 2'd3) begin
              state <= word_last ? ST_NEXT_ROW : ST_BLANK;
            end
          end
        end

        ST_BLANK: begin
          if (cell_ack) begin
            word_off <= word_off + 1'b1;
            state    <= ST_RD;
          end
        end

        ST_NEXT_ROW: begin
          if (row_last) begin
            state <= ST_FRAME_END;
          end else begin
            word_off <= word_off + 1'b1;
            state    <= ST_LABEL;
          end
        end

        ST_FRAME_END: begin
          if (!tb.ack) begin
            done_q   <= 1'b1;
            cell_adr <= HDR_BASE;
            word_off <= '0;
            nib_idx  <= 2'd0;
            spacer   <= 3'd3;
            lbl_cnt  <= 4'd0;
            state    <= ST_HDR;
          end
        end

        default: state <= ST_FRAME_END;
      endcase
    end
  end

  // Cell payload and the captured memory word
  always_ff @(posedge clk) begin
    if (issue) begin
      tb.adr <= cell_adr;
      tb.dat <= cell_dat;
    end
    if (state == ST_RD && rd_wait) begin
      word_q <= rd_dat_i;
    end
  end

endmodule

//--- design/text_buffer.sv
`timescale 1ns/1ps

module text_buffer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dump_pkg::TEXT_ADR_W-1:0] scan_adr_i,
  output logic [dump_pkg::WORD_W-1:0]     scan_dat_o,
  text_bus_if.slave                       tb
);
  import dump_pkg::*;

  localparam int CELLS = 2 ** TEXT_ADR_W;

  logic [WORD_W-1:0] mem [CELLS];
  logic              wr_stb;

  // Req seen high with ack still low marks a fresh request
  assign wr_stb = tb.req && !tb.ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      tb.ack <= 1'b0;
    end else begin
      if (wr_stb) begin
        tb.ack <= 1'b1;
      end else if (!tb.req && tb.ack) begin
        tb.ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_stb) begin
      mem[tb.adr] <= tb.dat;
    end
  end

  // Scan port, independent of the write side
  always_ff @(posedge clk) begin
    scan_dat_o <= mem[scan_adr_i];
  end

endmodule

//--- design/dump_sram.sv
`timescale 1ns/1ps

module dump_sram (
  input  logic                            clk,
  input  logic                            wr_en_i,
  input  logic [dump_pkg::WORD_ADR_W-1:0] wr_adr_i,
  input  logic [dump_pkg::WORD_W-1:0]     wr_dat_i,
  input  logic [dump_pkg::WORD_ADR_W-1:0] rd_adr_i,
  output logic [dump_pkg::WORD_W-1:0]     rd_dat_o
);
  import dump_pkg::*;

  localparam int WORDS = 2 ** WORD_ADR_W;

  logic [WORD_W-1:0] mem [WORDS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_adr_i] <= wr_dat_i;
    end
  end

  // Read data one clock after the address
  always_ff @(posedge clk) begin
    rd_dat_o <= mem[rd_adr_i];
  end

endmodule

//--- design/text_bus_if.sv
`timescale 1ns/1ps

interface text_bus_if;
  import dump_pkg::*;

  logic                  req;
  logic [TEXT_ADR_W-1:0] adr;
  logic [WORD_W-1:0]     dat;
  logic                  ack;

  // Four-phase write, master holds adr/dat while req is high
  modport master (
    output req, adr, dat,
    input  ack
  );

  modport slave (
    input  req, adr, dat,
    output ack
  );

endinterface

//--- design/dump_pkg.sv
package dump_pkg;

  // Screen geometry
  localparam int TEXT_ADR_W    = 11;
  localparam int SCREEN_COLS   = 80;
  localparam int DATA_ROWS     = 16;
  localparam int WORDS_PER_ROW = 16;

  localparam logic [TEXT_ADR_W-1:0] HDR_BASE  = 11'd80;
  localparam logic [TEXT_ADR_W-1:0] DATA_BASE = HDR_BASE + TEXT_ADR_W'(SCREEN_COLS);

  // Memory layout, page select above an 8-bit word offset
  localparam int PAGE_W     = 2;
  localparam int WORD_ADR_W = 10;
  localparam int WORD_W     = 16;

  // Cell attributes and characters
  localparam logic [7:0] ATTR_LABEL = 8'h05;
  localparam logic [7:0] ATTR_DATA  = 8'h07;
  localparam logic [7:0] CHAR_BLANK = 8'h20;

  // Lowercase hex digit for one nibble
  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    logic [7:0] wide;
    wide = {4'h0, nib};
    if (nib < 4'd10) begin
      return 8'h30 + wide;
    end else begin
      return 8'h57 + wide;
    end
  endfunction

endpackage
